// File: dv/programVectors.txt
# Tags: I word | D byteAddr word | W rd value | S byteAddr word ; all fields hex
# I words load from address 0 upward; W and S entries must occur in this order
I 00500093 # 00 addi x1, x0, 5
I 00308113 # 04 addi x2, x1, 3
I 002081B3 # 08 add  x3, x1, x2
I 40118233 # 0c sub  x4, x3, x1
I 003272B3 # 10 and  x5, x4, x3
I 0012E333 # 14 or   x6, x5, x1
I 002343B3 # 18 xor  x7, x6, x2
I 0063A433 # 1c slt  x8, x7, x6
I 01002483 # 20 lw   x9, 16(x0)
I 00148533 # 24 add  x10, x9, x1 (load-use)
I 00A02223 # 28 sw   x10, 4(x0)
I 00208663 # 2c beq  x1, x2, +12 (not taken)
I 00100593 # 30 addi x11, x0, 1
I 00200613 # 34 addi x12, x0, 2
I 00410663 # 38 beq  x2, x4, +12 (taken)
I 06300693 # 3c addi x13, x0, 99 (squashed)
I 06200713 # 40 addi x14, x0, 98 (squashed)
I 00C007EF # 44 jal  x15, +12
I 06100813 # 48 addi x16, x0, 97 (squashed)
I 06000893 # 4c addi x17, x0, 96 (squashed)
I 00802423 # 50 sw   x8, 8(x0)
I 00402903 # 54 lw   x18, 4(x0)
I 0000006F # 58 jal  x0, 0 (self-loop)
D 00000010 0000007B
W 01 00000005
W 02 00000008
W 03 0000000D
W 04 00000008
W 05 00000008
W 06 0000000D
W 07 00000005
W 08 00000001
W 09 0000007B
W 0a 00000080
W 0b 00000001
W 0c 00000002
W 0f 00000048
W 12 00000080
S 00000004 00000080
S 00000008 00000001

// File: project.f
design/corePkg.sv
design/hazardIf.sv
design/pipeReg.sv
design/controlDecoder.sv
design/regFile.sv
design/alu.sv
design/hazardUnit.sv
design/dataPath.sv
design/riscvCore.sv
dv/coreTb.sv

// File: dv/coreTb.sv
// Self-checking testbench; run from the project root so dv/programVectors.txt opens, memories are word models
`timescale 1ns/1ps

module coreTb import corePkg::*; ();

    localparam int IMEM_WORDS = 128;
    localparam int DMEM_WORDS = 256;
    localparam int MAX_EXPECT = 64;

    logic    clk;
    logic    rst;
    wordT    imemAddr;
    wordT    imemData;
    wordT    dmemAddr;
    wordT    dmemWriteData;
    logic    dmemWe;
    wordT    dmemReadData;
    logic    wbValid;
    regAddrT wbRd;
    wordT    wbData;

    wordT    imem [IMEM_WORDS];
    wordT    dmem [DMEM_WORDS];
    regAddrT expRd [MAX_EXPECT];
    wordT    expWbData [MAX_EXPECT];
    wordT    expAddr [MAX_EXPECT];
    wordT    expStData [MAX_EXPECT];

    int      instrCount, wbCount, stCount, wbIdx, stIdx;
    int      errors, checks, cycles, cycleLimit;
    logic    allSeen, resetChecked;

    integer           fd, scanned;
    logic [7:0]       tag;
    logic [8*256-1:0] restOfLine;
    wordT             fieldA, fieldB;

    riscvCore i_dut (
        .clk          (clk),
        .rst          (rst),
        .imemAddr     (imemAddr),
        .imemData     (imemData),
        .dmemAddr     (dmemAddr),
        .dmemWriteData(dmemWriteData),
        .dmemWe       (dmemWe),
        .dmemReadData (dmemReadData),
        .wbValid      (wbValid),
        .wbRd         (wbRd),
        .wbData       (wbData)
    );

    always #20 clk = ~clk;

    // ========================================================================
    // Memory models
    // ========================================================================
    assign imemData     = imem[imemAddr[8:2]];
    assign dmemReadData = dmem[dmemAddr[9:2]];

    always @(posedge clk) begin
        if (!rst && dmemWe) begin
            dmem[dmemAddr[9:2]] <= dmemWriteData;
        end
    end

    // Unused imem words carry the word index above a zero opcode, so they decode as no-ops
    // dmem background tracks the byte address
    task automatic fillMemories();
        int i;
        for (i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = wordT'(i) << 7;
        end
        for (i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = ~(wordT'(i) << 2);
        end
    endtask

    task automatic readVectors();
        while (!$feof(fd)) begin
            scanned = $fscanf(fd, " %c", tag);
            if (scanned == 1) begin
                case (tag)
                    "#": scanned = $fgets(restOfLine, fd);
                    "I": begin
                        scanned = $fscanf(fd, " %h", fieldA);
                        imem[instrCount] = fieldA;
                        instrCount++;
                    end
                    "D": begin
                        scanned = $fscanf(fd, " %h %h", fieldA, fieldB);
                        dmem[fieldA[9:2]] = fieldB;
                    end
                    "W": begin
                        scanned = $fscanf(fd, " %h %h", fieldA, fieldB);
                        expRd[wbCount]     = fieldA[4:0];
                        expWbData[wbCount] = fieldB;
                        wbCount++;
                    end
                    "S": begin
                        scanned = $fscanf(fd, " %h %h", fieldA, fieldB);
                        expAddr[stCount]   = fieldA;
                        expStData[stCount] = fieldB;
                        stCount++;
                    end
                    default: begin
                        $display("vector file holds an unknown tag %c", tag);
                        errors++;
                        scanned = $fgets(restOfLine, fd);
                    end
                endcase
            end
        end
        $fclose(fd);
    endtask

    // ========================================================================
    // Checks, sampled at the falling edge
    // ========================================================================
    task automatic checkIdle();
        checks++;
        if (wbValid !== 1'b0) begin
            $display("error wbValid expected %h got %h", 1'b0, wbValid);
            errors++;
        end
        if (dmemWe !== 1'b0) begin
            $display("error dmemWe expected %h got %h", 1'b0, dmemWe);
            errors++;
        end
        if (imemAddr !== 32'h0) begin
            $display("error imemAddr expected %h got %h", 32'h0, imemAddr);
            errors++;
        end
    endtask

    task automatic checkWriteback();
        if (wbRd == '0) begin
            $display("a writeback to x0 was flagged valid");
            errors++;
        end else if (wbIdx >= wbCount) begin
            $display("unexpected writeback to x%0d after all expected ones", wbRd);
            errors++;
        end else begin
            checks++;
            if (wbRd !== expRd[wbIdx]) begin
                $display("error wbRd expected %h got %h", expRd[wbIdx], wbRd);
                errors++;
            end
            if (wbData !== expWbData[wbIdx]) begin
                $display("error wbData expected %h got %h", expWbData[wbIdx], wbData);
                errors++;
            end
            wbIdx++;
        end
    endtask

    task automatic checkStore();
        if (stIdx >= stCount) begin
            $display("unexpected store to address %h after all expected ones", dmemAddr);
            errors++;
        end else begin
            checks++;
            if (dmemAddr !== expAddr[stIdx]) begin
                $display("error dmemAddr expected %h got %h", expAddr[stIdx], dmemAddr);
                errors++;
            end
            if (dmemWriteData !== expStData[stIdx]) begin
                $display("error dmemWriteData expected %h got %h", expStData[stIdx],
                         dmemWriteData);
                errors++;
            end
            stIdx++;
        end
    endtask

    // Reset cycles plus the first cycle after reset must be idle
    always @(negedge clk) begin
        if (rst || !resetChecked) begin
            checkIdle();
            if (!rst) begin
                resetChecked = 1'b1;
            end
        end else begin
            if (wbValid) begin
                checkWriteback();
            end
            if (dmemWe) begin
                checkStore();
            end
            if (wbIdx == wbCount && stIdx == stCount) begin
                allSeen = 1'b1;
            end
        end
    end

    // ========================================================================
    // Main sequence
    // ========================================================================
    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        instrCount   = 0;
        wbCount      = 0;
        stCount      = 0;
        wbIdx        = 0;
        stIdx        = 0;
        errors       = 0;
        checks       = 0;
        cycles       = 0;
        allSeen      = 1'b0;
        resetChecked = 1'b0;
        fillMemories();
        fd = $fopen("dv/programVectors.txt", "r");
        if (fd == 0) begin
            $display("could not open dv/programVectors.txt");
            errors++;
        end else begin
            readVectors();
        end
        cycleLimit = 8 * instrCount + 20;

        repeat (2) @(posedge clk);
        rst <= 1'b0;

        while (!allSeen && cycles < cycleLimit) begin
            @(posedge clk);
            cycles++;
        end
        if (!allSeen) begin
            $display("timeout after %0d cycles with %0d writebacks and %0d stores missing",
                     cycles, wbCount - wbIdx, stCount - stIdx);
            errors++;
        end
        $display("%0d writebacks, %0d stores, %0d checks, %0d errors in %0d cycles",
                 wbIdx, stIdx, checks, errors, cycles);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: design/riscvCore.sv
// RV32I subset core top; memories live outside and must answer reads in the same cycle
`timescale 1ns/1ps

module riscvCore import corePkg::*; (
    input  logic    clk,
    input  logic    rst,
    output wordT    imemAddr,
    input  wordT    imemData,
    output wordT    dmemAddr,
    output wordT    dmemWriteData,
    output logic    dmemWe,
    input  wordT    dmemReadData,
    output logic    wbValid,
    output regAddrT wbRd,
    output wordT    wbData
);

    hazardIf hz (.clk(clk));

    dataPath iDataPath (
        .clk          (clk),
        .rst          (rst),
        .hz           (hz.datapath),
        .imemAddr     (imemAddr),
        .imemData     (imemData),
        .dmemAddr     (dmemAddr),
        .dmemWriteData(dmemWriteData),
        .dmemWe       (dmemWe),
        .dmemReadData (dmemReadData),
        .wbValid      (wbValid),
        .wbRd         (wbRd),
        .wbData       (wbData)
    );

    hazardUnit iHazardUnit (
        .hz(hz.hazard)
    );

endmodule

// File: design/dataPath.sv
// Five-stage datapath; memories are external with combinational reads, branches resolve in execute
`timescale 1ns/1ps

module dataPath import corePkg::*; (
    input  logic             clk,
    input  logic             rst,
    hazardIf.datapath        hz,
    output wordT             imemAddr,
    input  wordT             imemData,
    output wordT             dmemAddr,
    output wordT             dmemWriteData,
    output logic             dmemWe,
    input  wordT             dmemReadData,
    output logic             wbValid,
    output regAddrT          wbRd,
    output wordT             wbData
);

    wordT    pcF, pcNextF, pcPlus4F;
    ifIdT    ifIdNext, ifId;
    idExT    idExNext, idEx;
    exMemT   exMemNext, exMem;
    memWbT   memWbNext, memWb;

    controlT ctrlD;
    wordT    immD, rd1D, rd2D;
    regAddrT rs1D, rs2D, rdD;

    wordT    srcAE, srcBE, writeDataE, aluResultE, targetE;
    logic    zeroE;
    wordT    resultW;

    // =========================================================================
    // Fetch
    // =========================================================================
    assign pcPlus4F = pcF + 32'd4;
    assign pcNextF  = hz.pcSrcE ? targetE : pcPlus4F;

    always_ff @(posedge clk) begin
        if (rst) begin
            pcF <= '0;
        end else if (!hz.stallF) begin
            pcF <= pcNextF;
        end
    end

    assign imemAddr = pcF;

    assign ifIdNext.instr   = imemData;
    assign ifIdNext.pc      = pcF;
    assign ifIdNext.pcPlus4 = pcPlus4F;

    pipeReg #(.T(ifIdT)) ifIdReg (
        .clk(clk), .rst(rst), .en(!hz.stallD), .clr(hz.flushD), .d(ifIdNext), .q(ifId)
    );

    // =========================================================================
    // Decode
    // =========================================================================
    controlDecoder iDecoder (
        .instr(ifId.instr), .ctrl(ctrlD), .imm(immD), .rs1(rs1D), .rs2(rs2D), .rd(rdD)
    );

    regFile iRegFile (
        .clk(clk), .ra1(rs1D), .ra2(rs2D), .rd1(rd1D), .rd2(rd2D),
        .wa(memWb.rd), .wd(resultW), .we(memWb.regWrite)
    );

    assign hz.rs1D = rs1D;
    assign hz.rs2D = rs2D;

    assign idExNext = '{control: ctrlD, rd1: rd1D, rd2: rd2D, pc: ifId.pc, imm: immD,
                        rs1: rs1D, rs2: rs2D, rd: rdD, pcPlus4: ifId.pcPlus4};

    pipeReg #(.T(idExT)) idExReg (
        .clk(clk), .rst(rst), .en(1'b1), .clr(hz.flushE), .d(idExNext), .q(idEx)
    );

    // =========================================================================
    // Execute
    // =========================================================================
    always_comb begin
        case (hz.forwardAE)
            FWD_MEM: srcAE = exMem.aluResult;
            FWD_WB:  srcAE = resultW;
            default: srcAE = idEx.rd1;
        endcase
        case (hz.forwardBE)
            FWD_MEM: writeDataE = exMem.aluResult;
            FWD_WB:  writeDataE = resultW;
            default: writeDataE = idEx.rd2;
        endcase
    end

    assign srcBE = idEx.control.aluSrc ? idEx.imm : writeDataE;

    alu iAlu (
        .a(srcAE), .b(srcBE), .op(idEx.control.aluOp), .pc(idEx.pc), .imm(idEx.imm),
        .result(aluResultE), .zero(zeroE), .target(targetE)
    );

    // Taken BEQ or JAL redirects fetch
    assign hz.pcSrcE      = (idEx.control.branch && zeroE) || idEx.control.jump;
    assign hz.rs1E        = idEx.rs1;
    assign hz.rs2E        = idEx.rs2;
    assign hz.rdE         = idEx.rd;
    assign hz.resultSrcE0 = (idEx.control.resultSrc == RES_MEM);

    assign exMemNext = '{regWrite: idEx.control.regWrite, memWrite: idEx.control.memWrite,
                         resultSrc: idEx.control.resultSrc, aluResult: aluResultE,
                         writeData: writeDataE, rd: idEx.rd, pcPlus4: idEx.pcPlus4};

    pipeReg #(.T(exMemT)) exMemReg (
        .clk(clk), .rst(rst), .en(1'b1), .clr(1'b0), .d(exMemNext), .q(exMem)
    );

    // =========================================================================
    // Memory and writeback
    // =========================================================================
    assign dmemAddr      = exMem.aluResult;
    assign dmemWriteData = exMem.writeData;
    assign dmemWe        = exMem.memWrite;
    assign hz.rdM        = exMem.rd;
    assign hz.regWriteM  = exMem.regWrite;

    assign memWbNext = '{regWrite: exMem.regWrite, resultSrc: exMem.resultSrc,
                         aluResult: exMem.aluResult, readData: dmemReadData,
                         rd: exMem.rd, pcPlus4: exMem.pcPlus4};

    pipeReg #(.T(memWbT)) memWbReg (
        .clk(clk), .rst(rst), .en(1'b1), .clr(1'b0), .d(memWbNext), .q(memWb)
    );

    always_comb begin
        case (memWb.resultSrc)
            RES_MEM: resultW = memWb.readData;
            RES_PC4: resultW = memWb.pcPlus4;
            default: resultW = memWb.aluResult;
        endcase
    end

    assign hz.rdW       = memWb.rd;
    assign hz.regWriteW = memWb.regWrite;
    assign wbValid      = memWb.regWrite;
    assign wbRd         = memWb.rd;
    assign wbData       = resultW;

    // Store strobe must be clean once the pipeline has been cleared
    assert property (@(posedge clk) disable iff (rst) !$isunknown(dmemWe))
        else $error("dmemWe is unknown");

endmodule

// File: design/hazardUnit.sv
// Forwarding from memory then writeback, one-cycle load-use stall, two-deep flush on redirect
`timescale 1ns/1ps

module hazardUnit import corePkg::*; (
    hazardIf.hazard hz
);

    logic lwStall;

    // Newest producer first; x0 is never forwarded
    function automatic logic [1:0] fwdSel(
        input regAddrT rs,
        input regAddrT rdM,
        input logic    weM,
        input regAddrT rdW,
        input logic    weW
    );
        logic [1:0] sel;
        sel = FWD_NONE;
        if (rs != '0 && weM && rs == rdM) begin
            sel = FWD_MEM;
        end else if (rs != '0 && weW && rs == rdW) begin
            sel = FWD_WB;
        end
        return sel;
    endfunction

    assign hz.forwardAE = fwdSel(hz.rs1E, hz.rdM, hz.regWriteM, hz.rdW, hz.regWriteW);
    assign hz.forwardBE = fwdSel(hz.rs2E, hz.rdM, hz.regWriteM, hz.rdW, hz.regWriteW);

    // Load in execute feeding the instruction in decode
    assign lwStall = hz.resultSrcE0 && (hz.rdE == hz.rs1D || hz.rdE == hz.rs2D);

    assign hz.stallF = lwStall;
    assign hz.stallD = lwStall;
    assign hz.flushD = hz.pcSrcE;
    assign hz.flushE = lwStall || hz.pcSrcE;

    // A load never redirects, so a stall and a decode flush cannot meet
    assert property (@(posedge hz.clk) !(hz.stallD && hz.flushD))
        else $error("stallD and flushD asserted together");

endmodule

// File: design/alu.sv
// Integer ALU for the six supported operations plus the PC-relative target adder
`timescale 1ns/1ps

module alu import corePkg::*; (
    input  wordT  a,
    input  wordT  b,
    input  aluOpE op,
    input  wordT  pc,
    input  wordT  imm,
    output wordT  result,
    output logic  zero,
    output wordT  target
);

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            // Signed compare
            ALU_SLT: result = {{(XLEN-1){1'b0}}, ($signed(a) < $signed(b))};
            default: result = '0;
        endcase
    end

    // Used by BEQ after a subtract
    assign zero = (result == '0);

    // Branch and JAL destination
    assign target = pc + imm;

endmodule

// File: design/regFile.sv
// 32x32 register file, x0 reads zero; a same-cycle write is bypassed to both read ports
`timescale 1ns/1ps

module regFile import corePkg::*; (
    input  logic    clk,
    input  regAddrT ra1,
    input  regAddrT ra2,
    output wordT    rd1,
    output wordT    rd2,
    input  regAddrT wa,
    input  wordT    wd,
    input  logic    we
);

    wordT regs [1:2**REG_ADDR_WIDTH-1];

    always_ff @(posedge clk) begin
        if (we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

    // Write-through so decode sees the value writeback is producing
    always_comb begin
        rd1 = (ra1 == '0) ? '0 : regs[ra1];
        if (we && wa != '0 && wa == ra1) begin
            rd1 = wd;
        end
        rd2 = (ra2 == '0) ? '0 : regs[ra2];
        if (we && wa != '0 && wa == ra2) begin
            rd2 = wd;
        end
    end

endmodule

// File: design/controlDecoder.sv
// Decodes ADD/SUB/AND/OR/XOR/SLT, ADDI, LW, SW, BEQ and JAL; anything else becomes a no-op
`timescale 1ns/1ps

module controlDecoder import corePkg::*; (
    input  wordT    instr,
    output controlT ctrl,
    output wordT    imm,
    output regAddrT rs1,
    output regAddrT rs2,
    output regAddrT rd
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7b5;
    wordT       immI, immS, immB, immJ;
    aluOpE      funcOp;
    logic       funcOk;

    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign funct7b5 = instr[30];
    assign rs1      = instr[19:15];
    assign rs2      = instr[24:20];
    assign rd       = instr[11:7];

    // Immediate formats, all sign-extended from bit 31
    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // Arithmetic funct3 map shared by R and I types; SUB only for R type
    always_comb begin
        funcOk = 1'b1;
        funcOp = ALU_ADD;
        case (funct3)
            3'b000: funcOp = (opcode == OP_RTYPE && funct7b5) ? ALU_SUB : ALU_ADD;
            3'b010: funcOp = ALU_SLT;
            3'b100: funcOp = ALU_XOR;
            3'b110: funcOp = ALU_OR;
            3'b111: funcOp = ALU_AND;
            default: funcOk = 1'b0;
        endcase
    end

    always_comb begin
        ctrl = '0;
        imm  = '0;
        case (opcode)
            OP_RTYPE: begin
                ctrl.regWrite = funcOk;
                ctrl.aluOp    = funcOp;
            end
            OP_ITYPE: begin
                ctrl.regWrite = funcOk;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = funcOp;
                imm           = immI;
            end
            OP_LOAD: begin
                // Word loads only
                ctrl.regWrite  = (funct3 == 3'b010);
                ctrl.aluSrc    = 1'b1;
                ctrl.resultSrc = RES_MEM;
                imm            = immI;
            end
            OP_STORE: begin
                ctrl.memWrite = (funct3 == 3'b010);
                ctrl.aluSrc   = 1'b1;
                imm           = immS;
            end
            OP_BRANCH: begin
                // BEQ compares by subtraction and tests the zero flag
                ctrl.branch = (funct3 == 3'b000);
                ctrl.aluOp  = ALU_SUB;
                imm         = immB;
            end
            OP_JAL: begin
                ctrl.regWrite  = 1'b1;
                ctrl.jump      = 1'b1;
                ctrl.resultSrc = RES_PC4;
                imm            = immJ;
            end
            default: ;
        endcase
        // Writes to x0 are dropped here so forwarding never sees them
        if (rd == '0) begin
            ctrl.regWrite = 1'b0;
        end
    end

endmodule

// File: design/pipeReg.sv
// Generic stage register; T must be a packed type whose all-zero value is a bubble
`timescale 1ns/1ps

module pipeReg #(
    parameter type T = logic [31:0]
) (
    input  logic clk,
    input  logic rst,
    input  logic en,
    input  logic clr,
    input  T     d,
    output T     q
);

    // Clear wins over enable so a flush also empties a held stage
    always_ff @(posedge clk) begin
        if (rst || clr) begin
            q <= '0;
        end else if (en) begin
            q <= d;
        end
    end

endmodule

// File: design/hazardIf.sv
// Datapath-to-hazard-unit signals; clk only feeds the hazard unit's checks, nothing is registered
`timescale 1ns/1ps

interface hazardIf import corePkg::*; (input logic clk);

    // Register indices and write enables seen by the hazard unit
    regAddrT    rs1D, rs2D;
    regAddrT    rs1E, rs2E, rdE;
    logic       resultSrcE0;
    logic       pcSrcE;
    regAddrT    rdM;
    logic       regWriteM;
    regAddrT    rdW;
    logic       regWriteW;

    // Pipeline control back to the datapath
    logic       stallF, stallD;
    logic       flushD, flushE;
    logic [1:0] forwardAE, forwardBE;

    modport datapath (
        output rs1D, rs2D, rs1E, rs2E, rdE, resultSrcE0, pcSrcE,
        output rdM, regWriteM, rdW, regWriteW,
        input  stallF, stallD, flushD, flushE, forwardAE, forwardBE
    );

    modport hazard (
        input  clk,
        input  rs1D, rs2D, rs1E, rs2E, rdE, resultSrcE0, pcSrcE,
        input  rdM, regWriteM, rdW, regWriteW,
        output stallF, stallD, flushD, flushE, forwardAE, forwardBE
    );

endinterface

// File: design/corePkg.sv
// Shared widths, opcodes and stage payloads; only the RV32I subset ADD..JAL is encoded here
package corePkg;

    // =========================================================================
    // Widths and basic types
    // =========================================================================
    localparam int XLEN           = 32;
    localparam int REG_ADDR_WIDTH = 5;

    typedef logic [XLEN-1:0]           wordT;
    typedef logic [REG_ADDR_WIDTH-1:0] regAddrT;

    // Major opcodes of the supported instructions
    localparam logic [6:0] OP_RTYPE  = 7'b0110011;
    localparam logic [6:0] OP_ITYPE  = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

    // Forwarding mux selects for the execute operands
    localparam logic [1:0] FWD_NONE = 2'b00;
    localparam logic [1:0] FWD_WB   = 2'b01;
    localparam logic [1:0] FWD_MEM  = 2'b10;

    // Zero encoding is ADD so that a cleared payload is harmless
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5
    } aluOpE;

    // Bit 0 set means a load
    typedef enum logic [1:0] {
        RES_ALU = 2'd0,
        RES_MEM = 2'd1,
        RES_PC4 = 2'd2
    } resultSrcE;

    // =========================================================================
    // Control bundle and stage payloads (all-zero is a bubble)
    // =========================================================================
    typedef struct packed {
        logic      regWrite;
        logic      memWrite;
        logic      aluSrc;
        logic      branch;
        logic      jump;
        resultSrcE resultSrc;
        aluOpE     aluOp;
    } controlT;

    typedef struct packed {
        wordT instr;
        wordT pc;
        wordT pcPlus4;
    } ifIdT;

    typedef struct packed {
        controlT control;
        wordT    rd1;
        wordT    rd2;
        wordT    pc;
        wordT    imm;
        regAddrT rs1;
        regAddrT rs2;
        regAddrT rd;
        wordT    pcPlus4;
    } idExT;

    typedef struct packed {
        logic      regWrite;
        logic      memWrite;
        resultSrcE resultSrc;
        wordT      aluResult;
        wordT      writeData;
        regAddrT   rd;
        wordT      pcPlus4;
    } exMemT;

    typedef struct packed {
        logic      regWrite;
        resultSrcE resultSrc;
        wordT      aluResult;
        wordT      readData;
        regAddrT   rd;
        wordT      pcPlus4;
    } memWbT;

endpackage
